// ==== build.f ====
+incdir+verilog
verilog/engine_pkg.sv
verilog/slice_timer.sv
verilog/thread_regfile.sv
verilog/arith_unit.sv
verilog/issue_ctrl.sv
verilog/arith_engine_top.sv
tests/tb_clock.sv
tests/arith_engine_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -f build.f --top-module arith_engine_tb \
  -o arith_engine_sim \
  && ./obj_dir/arith_engine_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qs "Test completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== tests/arith_engine_tb.sv ====
// Directed testbench for the two-thread arithmetic engine with a reference model
`timescale 1ns/1ns
`default_nettype none
`include "engine_macros.svh"

module arith_engine_tb;

  import engine_pkg::*;

  // Command budget per test
  localparam int BANK_CMDS   = 32;
  localparam int REG_OP_CMDS = 60;
  localparam int CMP_CMDS    = 20;
  localparam int IMM_CMDS    = 116;
  localparam int OVFL_CMDS   = 16;
  // Four ops plus the pauses, counted as four more slots
  localparam int RETIRE_CMDS = 8;
  localparam int NUM_CMDS    = BANK_CMDS + REG_OP_CMDS + CMP_CMDS + IMM_CMDS
                               + OVFL_CMDS + RETIRE_CMDS;
  localparam int WATCHDOG_CYCLES = NUM_CMDS * 10 + 200;
  localparam int ACK_LIMIT = 16;

  // Adder range limits
  localparam longint U_MAX = 64'sh0000_0000_ffff_ffff;
  localparam longint S_MAX = 64'sh0000_0000_7fff_ffff;
  localparam longint S_MIN = -64'sh0000_0000_8000_0000;

  logic        CLK;
  logic        RST;
  logic        req;
  host_cmd_t   cmd;
  logic        ack;
  host_resp_t  resp;
  logic [15:0] retired_0;
  logic [15:0] retired_1;

  // Reference state
  logic [31:0] regs_m [2][8];
  logic [27:0] imm_m [2];
  au_flags_t   flag_m [2];
  logic [15:0] exec_cnt [2];

  int seed;
  int errors;
  int checks;

  tb_clock clk_gen_i (
    .CLK (CLK),
    .RST (RST)
  );

  arith_engine_top dut_i (
    .CLK       (CLK),
    .RST       (RST),
    .req       (req),
    .cmd       (cmd),
    .ack       (ack),
    .resp      (resp),
    .retired_0 (retired_0),
    .retired_1 (retired_1)
  );

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  function automatic au_op_t make_op(input logic imm_sel, input logic [4:0] opcode,
                                     input logic [2:0] ra, input logic [2:0] rb,
                                     input logic [2:0] rc);
    au_op_t o;
    o.imm_sel = imm_sel;
    o.opcode  = opcode;
    o.ra_sel  = ra;
    o.rb_sel  = rb;
    o.rc_sel  = rc;
    return o;
  endfunction

  // Upper-immediate form, low four immediate bits ride in opcode[4] and rb_sel
  function automatic au_op_t imm_form(input logic [4:0] opcode, input logic [2:0] ra,
                                      input logic [3:0] low, input logic [2:0] rc);
    return make_op(1'b1, {low[3], opcode[3:0]}, ra, low[2:0], rc);
  endfunction

  function automatic logic [4:0] eff_opcode(input au_op_t op);
    return op.imm_sel ? {1'b0, op.opcode[3:0]} : op.opcode;
  endfunction

  // Expected result and flags of one operation
  task automatic model_exec(input logic t, input au_op_t op,
                            output logic [31:0] res, output au_flags_t fl);
    logic [31:0] a;
    logic [31:0] b;
    logic [3:0]  n;
    logic [4:0]  opc;
    longint      delta;
    longint      sum_u;
    longint      sum_s;
    a   = regs_m[t][op.ra_sel];
    b   = op.imm_sel ? {imm_m[t], op.opcode[4], op.rb_sel} : regs_m[t][op.rb_sel];
    opc = eff_opcode(op);
    // Small immediate 1..8
    n   = {1'b0, op.rb_sel} + 4'd1;
    case (opc)
      `OP_OR:   res = a | b;
      `OP_XOR:  res = a ^ b;
      `OP_CMP:  res = a - b;
      `OP_ADD:  res = a + b;
      `OP_SUB:  res = a - b;
      `OP_AND:  res = a & b;
      `OP_BSET: res = a | (32'd1 << op.rb_sel);
      `OP_BCLR: res = a & ~(32'd1 << op.rb_sel);
      `OP_SUBI: res = a - {28'd0, n};
      `OP_ADDI: res = a + {28'd0, n};
      `OP_SHL:  res = a << n;
      `OP_SHR:  res = a >> n;
      `OP_ASR:  res = $signed(a) >>> n;
      `OP_SEXT:
        case (op.rb_sel)
          3'd0:    res = {{24{a[7]}}, a[7:0]};
          3'd1:    res = {{16{a[15]}}, a[15:0]};
          3'd2:    res = {{8{a[23]}}, a[23:0]};
          default: res = a;
        endcase
      default:  res = 32'd0;
    endcase
    // Shared adder runs for every opcode, bit 0 picks add over subtract
    if (opc[3])
      delta = longint'({60'd0, n});
    else
      delta = longint'({{32{b[31]}}, b});
    if (!opc[0])
      delta = -delta;
    // Unsigned a moved by signed delta, and signed a moved by the same
    sum_u = longint'({32'd0, a}) + delta;
    sum_s = longint'({{32{a[31]}}, a}) + delta;
    fl.zero  = (res == 32'd0);
    fl.neg   = res[31];
    fl.sovfl = (sum_s > S_MAX) || (sum_s < S_MIN);
    fl.uovfl = (sum_u < 64'sd0) || (sum_u > U_MAX);
  endtask

  task automatic check_data(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERROR at %0t ns: %s = 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  task automatic check_flags(input au_flags_t got, input au_flags_t exp, input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERROR at %0t ns: %s = %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input logic [15:0] got, input logic [15:0] exp, input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERROR at %0t ns: %s = %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // Four-phase exchange, response taken while ack is high
  task automatic send_cmd(input host_cmd_t c, output host_resp_t r);
    int cycles;
    @(negedge CLK);
    cmd    = c;
    req    = 1'b1;
    cycles = 0;
    while (!ack && cycles < ACK_LIMIT)
    begin
      @(negedge CLK);
      cycles++;
    end
    if (!ack)
    begin
      errors++;
      $display("No ack from the DUT within %0d cycles at %0t ns", ACK_LIMIT, $time);
    end
    r      = resp;
    req    = 1'b0;
    cycles = 0;
    while (ack && cycles < ACK_LIMIT)
    begin
      @(negedge CLK);
      cycles++;
    end
    if (ack)
    begin
      errors++;
      $display("Ack stayed high after req dropped at %0t ns", $time);
    end
  endtask

  task automatic load_reg(input logic t, input logic [2:0] sel, input logic [31:0] d);
    host_cmd_t  c;
    host_resp_t r;
    c         = '0;
    c.kind    = CMD_LOAD_REG;
    c.thread  = t;
    c.reg_sel = sel;
    c.data    = d;
    send_cmd(c, r);
    check_data(r.data, d, "resp.data");
    regs_m[t][sel] = d;
  endtask

  task automatic load_imm(input logic t, input logic [31:0] d);
    host_cmd_t  c;
    host_resp_t r;
    c        = '0;
    c.kind   = CMD_LOAD_IMM;
    c.thread = t;
    c.data   = d;
    send_cmd(c, r);
    check_data(r.data, d, "resp.data");
    imm_m[t] = d[31:4];
  endtask

  // Read-back also returns the thread's kept flags
  task automatic read_reg(input logic t, input logic [2:0] sel);
    host_cmd_t  c;
    host_resp_t r;
    c         = '0;
    c.kind    = CMD_READ_REG;
    c.thread  = t;
    c.reg_sel = sel;
    send_cmd(c, r);
    check_data(r.data, regs_m[t][sel], "resp.data");
    check_flags(r.flags, flag_m[t], "resp.flags");
  endtask

  task automatic exec_op(input logic t, input au_op_t op, output host_resp_t r);
    host_cmd_t   c;
    logic [31:0] exp_res;
    au_flags_t   exp_fl;
    model_exec(t, op, exp_res, exp_fl);
    c        = '0;
    c.kind   = CMD_EXEC;
    c.thread = t;
    c.op     = op;
    send_cmd(c, r);
    check_data(r.data, exp_res, "resp.data");
    check_flags(r.flags, exp_fl, "resp.flags");
    flag_m[t] = exp_fl;
    // Compare leaves the destination alone
    if (eff_opcode(op) != `OP_CMP)
      regs_m[t][op.rc_sel] = exp_res;
    exec_cnt[t] = exec_cnt[t] + 16'd1;
  endtask

  // Same index, different value per thread
  task automatic bank_separation();
    for (int r = 0; r < 8; r++)
    begin
      load_reg(1'b0, r[2:0], rand_word());
      load_reg(1'b1, r[2:0], rand_word());
    end
    for (int r = 0; r < 8; r++)
    begin
      read_reg(1'b0, r[2:0]);
      read_reg(1'b1, r[2:0]);
    end
  endtask

  task automatic reg_reg_ops();
    logic [4:0] ops [5];
    host_resp_t r;
    ops = '{`OP_OR, `OP_XOR, `OP_ADD, `OP_SUB, `OP_AND};
    for (int k = 0; k < 5; k++)
    begin
      for (int i = 0; i < 3; i++)
      begin
        load_reg(i[0], 3'd1, rand_word());
        load_reg(i[0], 3'd2, rand_word());
        exec_op(i[0], make_op(1'b0, ops[k], 3'd1, 3'd2, 3'(4 + i)), r);
        read_reg(i[0], 3'(4 + i));
      end
    end
  endtask

  // Last case uses equal operands for a zero result
  task automatic compare_ops();
    logic [31:0] a;
    host_resp_t  r;
    for (int i = 0; i < 4; i++)
    begin
      a = rand_word();
      load_reg(i[0], 3'd1, a);
      load_reg(i[0], 3'd2, (i == 3) ? a : rand_word());
      load_reg(i[0], 3'd5, rand_word());
      exec_op(i[0], make_op(1'b0, `OP_CMP, 3'd1, 3'd2, 3'd5), r);
      read_reg(i[0], 3'd5);
    end
  endtask

  task automatic immediate_forms();
    logic [31:0] d;
    logic [31:0] a;
    host_resp_t  r;
    // Upper immediate as operand b
    for (int i = 0; i < 4; i++)
    begin
      d = rand_word();
      load_imm(i[0], d);
      load_reg(i[0], 3'd1, rand_word());
      exec_op(i[0], imm_form(`OP_ADD, 3'd1, d[3:0], 3'd3), r);
      read_reg(i[0], 3'd3);
      exec_op(i[0], imm_form(`OP_OR, 3'd1, d[3:0], 3'd4), r);
      read_reg(i[0], 3'd4);
    end
    // Small add and subtract, rb_sel n means n+1
    for (int n = 0; n < 8; n++)
    begin
      load_reg(n[0], 3'd1, rand_word());
      exec_op(n[0], make_op(1'b0, `OP_ADDI, 3'd1, n[2:0], 3'd2), r);
      exec_op(n[0], make_op(1'b0, `OP_SUBI, 3'd1, n[2:0], 3'd3), r);
    end
    // Bit set and clear on bits 0..7
    for (int n = 0; n < 8; n++)
    begin
      load_reg(n[0], 3'd1, rand_word());
      exec_op(n[0], make_op(1'b0, `OP_BSET, 3'd1, n[2:0], 3'd2), r);
      exec_op(n[0], make_op(1'b0, `OP_BCLR, 3'd1, n[2:0], 3'd3), r);
    end
    // Shifts by 1..8, sign bit alternating
    for (int n = 0; n < 8; n++)
    begin
      a     = rand_word();
      a[31] = n[0];
      load_reg(n[1], 3'd1, a);
      exec_op(n[1], make_op(1'b0, `OP_SHL, 3'd1, n[2:0], 3'd2), r);
      exec_op(n[1], make_op(1'b0, `OP_SHR, 3'd1, n[2:0], 3'd3), r);
      exec_op(n[1], make_op(1'b0, `OP_ASR, 3'd1, n[2:0], 3'd4), r);
    end
    // Sign-extend from bit 7, 15, 23
    for (int k = 0; k < 3; k++)
    begin
      for (int i = 0; i < 2; i++)
      begin
        load_reg(i[0], 3'd1, rand_word());
        exec_op(i[0], make_op(1'b0, `OP_SEXT, 3'd1, k[2:0], 3'd6), r);
      end
    end
  endtask

  task automatic ovfl_case(input logic t, input logic [31:0] a, input logic [31:0] b,
                           input logic [4:0] opcode, output host_resp_t r);
    load_reg(t, 3'd1, a);
    load_reg(t, 3'd2, b);
    exec_op(t, make_op(1'b0, opcode, 3'd1, 3'd2, 3'd3), r);
  endtask

  task automatic overflow_bounds();
    host_resp_t r;
    au_flags_t  exp;
    ovfl_case(1'b0, 32'h7fff_ffff, 32'd1, `OP_ADD, r);
    // Hand-worked boundary flags as a second opinion on the model
    exp = '{zero: 1'b0, neg: 1'b1, sovfl: 1'b1, uovfl: 1'b0};
    check_flags(r.flags, exp, "resp.flags");
    ovfl_case(1'b1, 32'd0, 32'd1, `OP_SUB, r);
    exp = '{zero: 1'b0, neg: 1'b1, sovfl: 1'b0, uovfl: 1'b1};
    check_flags(r.flags, exp, "resp.flags");
    ovfl_case(1'b0, 32'hffff_ffff, 32'd1, `OP_ADD, r);
    ovfl_case(1'b1, 32'h8000_0000, 32'd1, `OP_SUB, r);
    load_reg(1'b0, 3'd1, 32'h7fff_ffff);
    exec_op(1'b0, make_op(1'b0, `OP_ADDI, 3'd1, 3'd0, 3'd4), r);
    load_reg(1'b1, 3'd1, 32'd0);
    exec_op(1'b1, make_op(1'b0, `OP_SUBI, 3'd1, 3'd0, 3'd4), r);
  endtask

  task automatic retire_counts();
    host_resp_t r;
    check_count(retired_0, exec_cnt[0], "retired_0");
    check_count(retired_1, exec_cnt[1], "retired_1");
    // Idle gaps between commands
    for (int i = 0; i < 4; i++)
    begin
      repeat (10) @(negedge CLK);
      exec_op(i[0], make_op(1'b0, `OP_XOR, 3'd1, 3'd2, 3'd6), r);
    end
    check_count(retired_0, exec_cnt[0], "retired_0");
    check_count(retired_1, exec_cnt[1], "retired_1");
  endtask

  initial
  begin
    req    = 1'b0;
    cmd    = '0;
    seed   = 32'h3e07_64d0;
    errors = 0;
    checks = 0;
    for (int t = 0; t < 2; t++)
    begin
      for (int r = 0; r < 8; r++)
        regs_m[t][r] = 32'd0;
      imm_m[t]    = 28'd0;
      flag_m[t]   = '0;
      exec_cnt[t] = 16'd0;
    end
    @(negedge RST);
    @(negedge CLK);
    bank_separation();
    reg_reg_ops();
    compare_ops();
    immediate_forms();
    overflow_bounds();
    retire_counts();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

  // Watchdog
  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    $display("Watchdog expired after %0d cycles, command sequence never finished",
             WATCHDOG_CYCLES);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
// Testbench clock source with a power-on reset pulse
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
  output logic CLK,
  output logic RST
);

  // 10 ns period
  localparam int HALF_PERIOD  = 5;
  localparam int RESET_CYCLES = 8;

  initial
  begin
    CLK = 1'b0;
    forever #HALF_PERIOD CLK = ~CLK;
  end

  // Reset released on a falling edge, away from the DUT's sampling edge
  initial
  begin
    RST = 1'b1;
    repeat (RESET_CYCLES) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
  end

endmodule

`default_nettype wire

// ==== verilog/arith_engine_top.sv ====
// Two-thread register arithmetic engine with a four-phase host port
`timescale 1ns/1ns
`default_nettype none
`include "engine_macros.svh"

module arith_engine_top (
  input  wire                        CLK,
  input  wire                        RST,
  input  wire                        req,
  input  wire engine_pkg::host_cmd_t cmd,
  output logic                       ack,
  output engine_pkg::host_resp_t     resp,
  output logic [15:0]                retired_0,
  output logic [15:0]                retired_1
);

  import engine_pkg::*;

  logic                   slice;
  logic                   retire;
  logic                   op_vld;
  au_op_t                 op;
  logic                   imm_vld;
  logic [`ENG_IMM_W-1:0]  imm;
  logic [`ENG_SEL_W-1:0]  ra_sel;
  logic [`ENG_SEL_W-1:0]  rb_sel;
  logic [`ENG_DATA_W-1:0] ra;
  logic [`ENG_DATA_W-1:0] rb;
  logic [`ENG_SEL_W-1:0]  rd_sel;
  logic [`ENG_DATA_W-1:0] rd_data;
  au_flags_t              flags;
  rf_wr_t                 au_wr;
  rf_wr_t                 load_wr;
  rf_wr_t                 rf_wr;

  // Loads never overlap an operation in flight
  assign rf_wr = au_wr.en ? au_wr : load_wr;

  slice_timer timer_i (
    .CLK       (CLK),
    .RST       (RST),
    .retire    (retire),
    .slice     (slice),
    .retired_0 (retired_0),
    .retired_1 (retired_1)
  );

  thread_regfile regfile_i (
    .CLK     (CLK),
    .RST     (RST),
    .slice   (slice),
    .ra_sel  (ra_sel),
    .rb_sel  (rb_sel),
    .ra      (ra),
    .rb      (rb),
    .wr      (rf_wr),
    .rd_sel  (rd_sel),
    .rd_data (rd_data)
  );

  arith_unit au_i (
    .CLK     (CLK),
    .RST     (RST),
    .slice   (slice),
    .op_vld  (op_vld),
    .op      (op),
    .imm_vld (imm_vld),
    .imm     (imm),
    .ra_sel  (ra_sel),
    .rb_sel  (rb_sel),
    .ra      (ra),
    .rb      (rb),
    .wr      (au_wr),
    .flags   (flags)
  );

  issue_ctrl ctrl_i (
    .CLK     (CLK),
    .RST     (RST),
    .req     (req),
    .cmd     (cmd),
    .ack     (ack),
    .resp    (resp),
    .slice   (slice),
    .op_vld  (op_vld),
    .op      (op),
    .imm_vld (imm_vld),
    .imm     (imm),
    .load_wr (load_wr),
    .rd_sel  (rd_sel),
    .rd_data (rd_data),
    .au_wr   (au_wr),
    .flags   (flags),
    .retire  (retire)
  );

endmodule

`default_nettype wire

// ==== verilog/arith_unit.sv ====
// Arithmetic unit with operand stage, result mux and per-thread flags and immediate holds
`timescale 1ns/1ns
`default_nettype none
`include "engine_macros.svh"

module arith_unit (
  input  wire                        CLK,
  input  wire                        RST,
  input  wire                        slice,
  input  wire                        op_vld,
  input  wire engine_pkg::au_op_t    op,
  input  wire                        imm_vld,
  input  wire [`ENG_IMM_W-1:0]       imm,
  output logic [`ENG_SEL_W-1:0]      ra_sel,
  output logic [`ENG_SEL_W-1:0]      rb_sel,
  input  wire [`ENG_DATA_W-1:0]      ra,
  input  wire [`ENG_DATA_W-1:0]      rb,
  output engine_pkg::rf_wr_t         wr,
  output engine_pkg::au_flags_t      flags
);

  import engine_pkg::*;

  logic [1:0][`ENG_IMM_W-1:0] imm_hold;
  logic [`ENG_DATA_W-1:0]     imm_word;
  logic [4:0]                 op_mux;

  // Operand stage
  logic [`ENG_DATA_W-1:0] reg_a;
  logic [`ENG_DATA_W-1:0] reg_b;
  logic [3:0]             small_imm;
  logic [4:0]             op_d1;
  logic [`ENG_SEL_W-1:0]  rc_d1;
  logic                   thread_d1;
  logic                   res_vld;

  // Result path
  logic [`ENG_DATA_W:0]   add_value;
  logic [`ENG_DATA_W:0]   add_sub;
  logic [`ENG_DATA_W:0]   add_result;
  logic [`ENG_DATA_W-1:0] bit_mask;
  logic [`ENG_DATA_W-1:0] result;
  au_flags_t              res_flags;
  au_flags_t [1:0]        flag_q;

  // Upper immediate holds, written on the owning thread's slice
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
      imm_hold <= '0;
    else if (imm_vld)
      imm_hold[slice] <= imm;
  end

  // Decode
  // Immediate word is hold bits, then opcode top bit, then rb_sel
  assign imm_word = {imm_hold[slice], op.opcode[4], op.rb_sel};
  assign op_mux   = op.opcode & (op.imm_sel ? 5'h0F : 5'h1F);
  assign ra_sel   = op.ra_sel;
  assign rb_sel   = op.rb_sel;

  // Operands captured at issue
  always_ff @(posedge CLK)
  begin
    if (op_vld)
    begin
      reg_a     <= ra;
      reg_b     <= op.imm_sel ? imm_word : rb;
      small_imm <= {1'b0, op.rb_sel} + 4'd1;
      op_d1     <= op_mux;
      rc_d1     <= op.rc_sel;
      thread_d1 <= slice;
    end
  end

  // Result valid one cycle after issue
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
      res_vld <= 1'b0;
    else
      res_vld <= op_vld;
  end

  always_comb
  begin
    // Small forms add 1..8, others sign-extend b to 33 bits
    add_value  = op_d1[3] ? {{(`ENG_DATA_W - 3){1'b0}}, small_imm} : {reg_b[31], reg_b};
    // Opcode bit 0 clear means subtract
    add_sub    = op_d1[0] ? add_value : (~add_value + 33'd1);
    add_result = {reg_a[31], reg_a} + add_sub;
    bit_mask   = 32'd1 << (small_imm - 4'd1);

    case (op_d1)
      `OP_OR:   result = reg_a | reg_b;
      `OP_XOR:  result = reg_a ^ reg_b;
      `OP_CMP:  result = add_result[31:0];
      `OP_ADD:  result = add_result[31:0];
      `OP_SUB:  result = add_result[31:0];
      `OP_AND:  result = reg_a & reg_b;
      `OP_BSET: result = reg_a | bit_mask;
      `OP_BCLR: result = reg_a & ~bit_mask;
      `OP_SUBI: result = add_result[31:0];
      `OP_ADDI: result = add_result[31:0];
      `OP_SHL:  result = reg_a << small_imm;
      `OP_SHR:  result = reg_a >> small_imm;
      `OP_ASR:  result = $signed(reg_a) >>> small_imm;
      // Extend from bit 7, 15 or 23, else pass through
      `OP_SEXT:
        case (small_imm)
          4'd1:    result = {{24{reg_a[7]}}, reg_a[7:0]};
          4'd2:    result = {{16{reg_a[15]}}, reg_a[15:0]};
          4'd3:    result = {{8{reg_a[23]}}, reg_a[23:0]};
          default: result = reg_a;
        endcase
      default:  result = '0;
    endcase
  end

  // Flags from this result
  assign res_flags.zero  = (result == '0);
  assign res_flags.neg   = result[31];
  assign res_flags.sovfl = add_result[32] ^ add_result[31];
  // Carry out of the unsigned add or borrow on subtract
  assign res_flags.uovfl = (reg_a[31] && !add_sub[32] && !add_result[32]) ||
                           (!reg_a[31] && add_sub[32] && add_result[31]);

  // Flags kept per issuing thread
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
      flag_q <= '0;
    else if (res_vld)
      flag_q[thread_d1] <= res_flags;
  end

  assign flags = flag_q[slice];

  // Compare computes but never writes back
  assign wr = '{en:     res_vld && (op_d1 != `OP_CMP),
                thread: thread_d1,
                sel:    rc_d1,
                data:   result};

  // One operation per slice pair, never on adjacent cycles
  a_no_back_to_back: assert property (
    @(posedge CLK) disable iff (RST)
    op_vld |=> !op_vld
  );

  a_defined_op: assert property (
    @(posedge CLK) disable iff (RST)
    op_vld |-> (op_mux inside {[`OP_OR:`OP_AND], [`OP_BSET:`OP_SEXT]})
  );

endmodule

`default_nettype wire

// ==== verilog/engine_macros.svh ====
// Engine sizing constants and arithmetic opcode values
`ifndef ENGINE_MACROS_SVH
`define ENGINE_MACROS_SVH

// Register file and datapath sizing
`define ENG_NUM_REGS 8
`define ENG_SEL_W    3
`define ENG_DATA_W   32
`define ENG_IMM_W    28

// Register-register forms
`define OP_OR   5'h00
`define OP_XOR  5'h01
`define OP_CMP  5'h02
`define OP_ADD  5'h03
`define OP_SUB  5'h04
`define OP_AND  5'h05

// Small immediate forms, rb_sel holds the value minus one
`define OP_BSET 5'h08
`define OP_BCLR 5'h09
`define OP_SUBI 5'h0A
`define OP_ADDI 5'h0B
`define OP_SHL  5'h0C
`define OP_SHR  5'h0D
`define OP_ASR  5'h0E
`define OP_SEXT 5'h0F

`endif

// ==== verilog/engine_pkg.sv ====
// Command, operation, response and flag types of the arithmetic engine
`default_nettype none
`include "engine_macros.svh"

package engine_pkg;

  // Host command kinds
  typedef enum logic [1:0] {
    CMD_LOAD_REG,
    CMD_LOAD_IMM,
    CMD_EXEC,
    CMD_READ_REG
  } cmd_kind_e;

  // 15-bit arithmetic operation word
  typedef struct packed {
    // Operand b from upper immediate hold
    logic                  imm_sel;
    // Top bit is immediate bit 3 when imm_sel is set
    logic [4:0]            opcode;
    logic [`ENG_SEL_W-1:0] ra_sel;
    // Also immediate bits 2..0 or small immediate minus one
    logic [`ENG_SEL_W-1:0] rb_sel;
    logic [`ENG_SEL_W-1:0] rc_sel;
  } au_op_t;

  typedef struct packed {
    cmd_kind_e              kind;
    logic                   thread;
    au_op_t                 op;
    logic [`ENG_SEL_W-1:0]  reg_sel;
    logic [`ENG_DATA_W-1:0] data;
  } host_cmd_t;

  typedef struct packed {
    logic zero;
    logic neg;
    logic sovfl;
    logic uovfl;
  } au_flags_t;

  typedef struct packed {
    logic [`ENG_DATA_W-1:0] data;
    au_flags_t              flags;
  } host_resp_t;

  // Register file write bundle
  typedef struct packed {
    logic                   en;
    logic                   thread;
    logic [`ENG_SEL_W-1:0]  sel;
    logic [`ENG_DATA_W-1:0] data;
  } rf_wr_t;

endpackage

`default_nettype wire

// ==== verilog/issue_ctrl.sv ====
// Issue controller FSM that runs host commands against the owning thread's slice
`timescale 1ns/1ns
`default_nettype none
`include "engine_macros.svh"

module issue_ctrl (
  input  wire                         CLK,
  input  wire                         RST,
  input  wire                         req,
  input  wire engine_pkg::host_cmd_t  cmd,
  output logic                        ack,
  output engine_pkg::host_resp_t      resp,
  input  wire                         slice,
  output logic                        op_vld,
  output engine_pkg::au_op_t          op,
  output logic                        imm_vld,
  output logic [`ENG_IMM_W-1:0]       imm,
  output engine_pkg::rf_wr_t          load_wr,
  output logic [`ENG_SEL_W-1:0]       rd_sel,
  input  wire [`ENG_DATA_W-1:0]       rd_data,
  input  wire engine_pkg::rf_wr_t     au_wr,
  input  wire engine_pkg::au_flags_t  flags,
  output logic                        retire
);

  import engine_pkg::*;

  typedef enum logic [2:0] {IDLE, WAIT_SLICE, EXEC, RESULT, ACK, RELEASE} state_e;

  state_e                 state;
  host_cmd_t              cmd_q;
  logic [`ENG_DATA_W-1:0] data_q;
  au_flags_t              flags_q;
  logic                   load_en_q;
  logic                   slice_hit;

  // First cycle owned by the command's thread
  assign slice_hit = (state == WAIT_SLICE) && (slice == cmd_q.thread);

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
      state <= IDLE;
    else
    begin
      case (state)
        IDLE:
          if (req)
            state <= WAIT_SLICE;
        WAIT_SLICE:
          if (slice_hit)
          begin
            if (cmd_q.kind == CMD_EXEC)
              state <= EXEC;
            else
              state <= ACK;
          end
        // Write-back cycle, other thread's slice
        EXEC:
          state <= RESULT;
        // Back on the issuing slice, ack goes up here
        RESULT:
          if (req)
            state <= ACK;
          else
            state <= RELEASE;
        ACK:
          if (!req)
            state <= RELEASE;
        RELEASE:
          state <= IDLE;
        default:
          state <= IDLE;
      endcase
    end
  end

  // Command and response payload
  always_ff @(posedge CLK)
  begin
    if ((state == IDLE) && req)
      cmd_q <= cmd;
    if (slice_hit)
    begin
      flags_q <= flags;
      data_q  <= (cmd_q.kind == CMD_READ_REG) ? rd_data : cmd_q.data;
    end
    // Result held from write-back, even for compare
    if (state == EXEC)
      data_q <= au_wr.data;
    if (state == RESULT)
      flags_q <= flags;
  end

  // Host load lands in the cycle after the slice hit
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
      load_en_q <= 1'b0;
    else
      load_en_q <= slice_hit && (cmd_q.kind == CMD_LOAD_REG);
  end

  assign op_vld  = slice_hit && (cmd_q.kind == CMD_EXEC);
  assign op      = cmd_q.op;
  assign imm_vld = slice_hit && (cmd_q.kind == CMD_LOAD_IMM);
  // Upper immediate sits in the top bits of the data word
  assign imm     = cmd_q.data[`ENG_DATA_W-1:`ENG_DATA_W-`ENG_IMM_W];
  assign rd_sel  = cmd_q.reg_sel;

  assign load_wr = '{en:     load_en_q,
                     thread: cmd_q.thread,
                     sel:    cmd_q.reg_sel,
                     data:   cmd_q.data};

  assign retire = (state == RESULT);
  assign ack    = (state == RESULT) || (state == ACK);
  // Live flags while they are being sampled
  assign resp   = '{data:  data_q,
                    flags: (state == RESULT) ? flags : flags_q};

  // Ack only answers a request that was held
  a_ack_needs_req: assert property (
    @(posedge CLK) disable iff (RST)
    $rose(ack) |-> $past(req)
  );

endmodule

`default_nettype wire

// ==== verilog/slice_timer.sv ====
// Slice alternator with per-thread retired operation counters
`timescale 1ns/1ns
`default_nettype none

module slice_timer (
  input  wire         CLK,
  input  wire         RST,
  input  wire         retire,
  output logic        slice,
  output logic [15:0] retired_0,
  output logic [15:0] retired_1
);

  // Thread ownership flips every cycle
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
      slice <= 1'b0;
    else
      slice <= ~slice;
  end

  // Retire pulse counts for the thread owning this cycle
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      retired_0 <= 16'd0;
      retired_1 <= 16'd0;
    end
    else if (retire)
    begin
      if (slice)
        retired_1 <= retired_1 + 16'd1;
      else
        retired_0 <= retired_0 + 16'd1;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/thread_regfile.sv ====
// Two-bank thread register file with two operand ports, a host read port and one write port
`timescale 1ns/1ns
`default_nettype none
`include "engine_macros.svh"

module thread_regfile (
  input  wire                     CLK,
  input  wire                     RST,
  input  wire                     slice,
  input  wire [`ENG_SEL_W-1:0]    ra_sel,
  input  wire [`ENG_SEL_W-1:0]    rb_sel,
  output logic [`ENG_DATA_W-1:0]  ra,
  output logic [`ENG_DATA_W-1:0]  rb,
  input  wire engine_pkg::rf_wr_t wr,
  input  wire [`ENG_SEL_W-1:0]    rd_sel,
  output logic [`ENG_DATA_W-1:0]  rd_data
);

  // One bank per thread
  logic [`ENG_DATA_W-1:0] bank [2][`ENG_NUM_REGS];

  // Write bank is named by the bundle, not by the slice
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      for (int t = 0; t < 2; t++)
        for (int r = 0; r < `ENG_NUM_REGS; r++)
          bank[t][r] <= '0;
    end
    else if (wr.en)
      bank[wr.thread][wr.sel] <= wr.data;
  end

  // All reads come from the bank of the owning thread
  assign ra      = bank[slice][ra_sel];
  assign rb      = bank[slice][rb_sel];
  assign rd_data = bank[slice][rd_sel];

  // Write-back lands one cycle after issue and host loads are registered,
  // so a write never hits the bank being read this cycle
  a_wr_other_bank: assert property (
    @(posedge CLK) disable iff (RST)
    wr.en |-> (wr.thread != slice)
  );

endmodule

`default_nettype wire
